// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pcs_rx_tb
FILELIST  ?= pcs_rx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== pcs_rx.f ====
verilog/pcs_block_pkg.sv
verilog/pcs_monitor_pkg.sv
verilog/pcs_block_if.sv
verilog/block_lock.sv
verilog/ber_monitor.sv
verilog/descrambler.sv
verilog/pcs_rx.sv
testbench/clock_gen.sv
testbench/pcs_rx_tb.sv

// ==== testbench/clock_gen.sv ====
module clock_gen
(
        output logic o_clock,
        output logic o_reset
);

        // Free running clock with a period of 20.
        initial
        begin
                o_clock = 1'b0;
                forever #10 o_clock = ~o_clock;
        end

        // Reset is held for the first four rising edges and released just
        // after the fourth, like any other input.
        initial
        begin
                o_reset = 1'b1;
                repeat (4) @(posedge o_clock);
                #2;
                o_reset = 1'b0;
        end

endmodule

// ==== testbench/pcs_rx_tb.sv ====
module pcs_rx_tb
        import pcs_block_pkg::*;
        import pcs_monitor_pkg::*;
();

        logic        clock;
        logic        reset;
        logic        i_valid;
        logic [65:0] i_block;
        logic        o_slip;
        logic        o_block_lock;
        logic        o_hi_ber;
        logic        o_valid;
        logic        o_is_ctrl;
        logic [7:0]  o_block_type;
        logic [63:0] o_data;
        logic        o_sh_error;

        integer      seed;
        int          cycle;
        int          value_errors;
        int          other_errors;
        int          blocks_sent;
        int          blocks_since_lock;
        logic [57:0] tx_hist;

        // The expected outputs hold one entry per block sent, oldest first.
        logic [63:0] exp_plain[$];
        logic [1:0]  exp_sh[$];
        int          exp_due[$];
        bit          exp_chk[$];
        string       exp_test[$];

        clock_gen clock_gen_i
        (
                .o_clock (clock),
                .o_reset (reset)
        );

        pcs_rx pcs_rx_i
        (
                .i_clock      (clock),
                .i_reset      (reset),
                .i_valid      (i_valid),
                .i_block      (i_block),
                .o_slip       (o_slip),
                .o_block_lock (o_block_lock),
                .o_hi_ber     (o_hi_ber),
                .o_valid      (o_valid),
                .o_is_ctrl    (o_is_ctrl),
                .o_block_type (o_block_type),
                .o_data       (o_data),
                .o_sh_error   (o_sh_error)
        );

        always @(posedge clock)
                cycle <= cycle + 1;

        // ==================================================
        // Stimulus and reference model
        // ==================================================

        function automatic logic [63:0] random_payload();
                random_payload = {$random(seed), $random(seed)};
        endfunction

        // The transmit scrambler works one bit at a time, LSB first.
        // tx_hist[0] is the bit sent last, tx_hist[57] the one sent 58 bits ago.
        task automatic scramble_block(input logic [63:0] plain, output logic [63:0] line);
                logic bit_out;
                for (int i = 0; i < 64; i++)
                begin
                        bit_out = plain[i] ^ tx_hist[38] ^ tx_hist[57];
                        tx_hist = {tx_hist[56:0], bit_out};
                        line[i] = bit_out;
                end
        endtask

        // Starts and ends 2 time units after a rising edge.
        task automatic send_block(input string test, input logic [1:0] sh,
                                  input logic [63:0] plain);
                logic [63:0] line;
                scramble_block(plain, line);
                i_valid = 1'b1;
                i_block = {sh, line};
                exp_plain.push_back(plain);
                exp_sh.push_back(sh);
                exp_due.push_back(cycle + 3);
                // The descrambler state is unknown until one block has passed.
                exp_chk.push_back(blocks_sent != 0);
                exp_test.push_back(test);
                blocks_sent++;
                blocks_since_lock++;
                @(posedge clock);
                #2;
                i_valid = 1'b0;
        endtask

        task automatic idle_cycle();
                @(posedge clock);
                #2;
        endtask

        // Good blocks until the next block starts a window of the given length.
        task automatic pad_to_window(input string test, input int period);
                while (blocks_since_lock % period != 0)
                        send_block(test, SH_DATA, random_payload());
        endtask

        task automatic check_value(input string test, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
                assert (actual === expected)
                else
                begin
                        $display("FAIL %s: %s expected %0h actual %0h",
                                 test, what, expected, actual);
                        value_errors++;
                end
        endtask

        task automatic wait_drain(input string test);
                int n;
                n = 0;
                while (exp_due.size() != 0 && n < 8)
                begin
                        idle_cycle();
                        n++;
                end
                if (exp_due.size() != 0)
                begin
                        $display("Timeout in %s: blocks still missing at the output", test);
                        other_errors++;
                end
        endtask

        // ==================================================
        // Output monitor
        // ==================================================

        task automatic compare_output();
                string       test;
                logic [63:0] plain;
                logic [1:0]  sh;
                int          due;
                bit          chk;
                logic        is_ctrl;
                test    = exp_test.pop_front();
                plain   = exp_plain.pop_front();
                sh      = exp_sh.pop_front();
                due     = exp_due.pop_front();
                chk     = exp_chk.pop_front();
                is_ctrl = (sh == SH_CTRL);
                check_value(test, "output cycle", due, cycle);
                check_value(test, "o_is_ctrl", is_ctrl, o_is_ctrl);
                check_value(test, "o_sh_error", !(sh == SH_DATA || sh == SH_CTRL), o_sh_error);
                if (chk)
                        check_value(test, "o_data", plain, o_data);
                if (chk && is_ctrl)
                        check_value(test, "o_block_type", plain[7:0], o_block_type);
        endtask

        // Outputs are sampled on the falling edge, half a cycle after they change.
        always @(negedge clock)
        begin
                if (o_valid === 1'b1)
                begin
                        if (exp_due.size() == 0)
                        begin
                                $display("An unexpected block came out at cycle %0d", cycle);
                                other_errors++;
                        end
                        else
                        begin
                                compare_output();
                        end
                end
                else if (exp_due.size() != 0 && exp_due[0] <= cycle)
                begin
                        $display("A block sent in %s did not come out at cycle %0d",
                                 exp_test[0], exp_due[0]);
                        other_errors++;
                        void'(exp_test.pop_front());
                        void'(exp_plain.pop_front());
                        void'(exp_sh.pop_front());
                        void'(exp_due.pop_front());
                        void'(exp_chk.pop_front());
                end
        end

        // ==================================================
        // Tests
        // ==================================================

        task automatic reset_values();
                check_value("reset_values", "o_valid", 0, o_valid);
                check_value("reset_values", "o_slip", 0, o_slip);
                check_value("reset_values", "o_block_lock", 0, o_block_lock);
                check_value("reset_values", "o_hi_ber", 0, o_hi_ber);
        endtask

        task automatic lock_and_slip();
                int n;
                for (n = 0; n < 4; n++)
                begin
                        send_block("lock_and_slip", (n % 2) ? 2'b11 : 2'b00, random_payload());
                        check_value("lock_and_slip", "o_slip", 1, o_slip);
                        check_value("lock_and_slip", "o_block_lock", 0, o_block_lock);
                end
                idle_cycle();
                check_value("lock_and_slip", "o_slip after idle", 0, o_slip);
                for (n = 0; n < LOCK_GOOD_COUNT; n++)
                begin
                        send_block("lock_and_slip", SH_DATA, random_payload());
                        check_value("lock_and_slip", "o_slip", 0, o_slip);
                        check_value("lock_and_slip", "o_block_lock",
                                    n == LOCK_GOOD_COUNT - 1, o_block_lock);
                end
                blocks_since_lock = 0;
                wait_drain("lock_and_slip");
        endtask

        task automatic descramble_data();
                int n;
                for (n = 0; n < 32; n++)
                        send_block("descramble_data", SH_DATA, random_payload());
                check_value("descramble_data", "o_block_lock", 1, o_block_lock);
                wait_drain("descramble_data");
        endtask

        task automatic classify_control();
                logic [7:0]  types [6];
                logic [63:0] plain;
                int          n;
                types = '{8'h1e, 8'h2d, 8'h33, 8'h4b, 8'h78, 8'hff};
                for (n = 0; n < 6; n++)
                begin
                        plain      = random_payload();
                        plain[7:0] = types[n];
                        send_block("classify_control", SH_CTRL, plain);
                end
                wait_drain("classify_control");
        endtask

        task automatic high_ber();
                int n;
                int n_good;
                pad_to_window("high_ber", BER_WINDOW_BLOCKS);
                // Eight bad headers come one every 8 blocks, all in one window.
                for (n = 0; n < 8 * HI_BER_THRESHOLD; n++)
                begin
                        if (n == 8 * (HI_BER_THRESHOLD - 1))
                                check_value("high_ber", "o_hi_ber before last error", 0, o_hi_ber);
                        send_block("high_ber", (n % 8 == 0) ? 2'b00 : SH_DATA, random_payload());
                        check_value("high_ber", "o_block_lock", 1, o_block_lock);
                end
                check_value("high_ber", "o_hi_ber", 1, o_hi_ber);
                n_good = 0;
                while (o_hi_ber && n_good < 3 * BER_WINDOW_BLOCKS)
                begin
                        send_block("high_ber", SH_DATA, random_payload());
                        n_good++;
                end
                if (o_hi_ber)
                begin
                        $display("Timeout in high_ber: o_hi_ber stayed high after clean windows");
                        other_errors++;
                end
                // The rest of the error window and one clean window pass, then
                // one more block while the level crosses the second stage.
                check_value("high_ber", "clean blocks until o_hi_ber fell",
                            2 * BER_WINDOW_BLOCKS - 8 * HI_BER_THRESHOLD + 1, n_good);
                wait_drain("high_ber");
        endtask

        task automatic loss_of_lock();
                int n;
                pad_to_window("loss_of_lock", UNLOCK_WINDOW);
                for (n = 0; n < UNLOCK_BAD_LIMIT; n++)
                begin
                        check_value("loss_of_lock", "o_block_lock", 1, o_block_lock);
                        if (n == UNLOCK_BAD_LIMIT - 1)
                                check_value("loss_of_lock", "o_hi_ber", 1, o_hi_ber);
                        send_block("loss_of_lock", 2'b11, random_payload());
                        check_value("loss_of_lock", "o_slip while locked", 0, o_slip);
                end
                check_value("loss_of_lock", "o_block_lock after errors", 0, o_block_lock);
                check_value("loss_of_lock", "o_hi_ber as lock falls", 1, o_hi_ber);
                n = 0;
                while (o_hi_ber && n < 4)
                begin
                        idle_cycle();
                        n++;
                end
                if (o_hi_ber)
                begin
                        $display("Timeout in loss_of_lock: o_hi_ber did not fall after lock loss");
                        other_errors++;
                end
                for (n = 0; n < 3; n++)
                begin
                        send_block("loss_of_lock", 2'b00, random_payload());
                        check_value("loss_of_lock", "o_slip", 1, o_slip);
                end
                wait_drain("loss_of_lock");
        endtask

        task automatic header_error();
                send_block("header_error", 2'b00, random_payload());
                send_block("header_error", SH_DATA, random_payload());
                send_block("header_error", 2'b11, random_payload());
                send_block("header_error", SH_CTRL, random_payload());
                wait_drain("header_error");
        endtask

        // ==================================================
        // Main sequence
        // ==================================================

        initial
        begin
                int n;
                seed              = 32'hfb011958;
                cycle             = 0;
                value_errors      = 0;
                other_errors      = 0;
                blocks_sent       = 0;
                blocks_since_lock = 0;
                tx_hist           = '1;
                i_valid           = 1'b0;
                i_block           = '0;

                n = 0;
                @(posedge clock);
                while (reset !== 1'b0 && n < 20)
                begin
                        @(posedge clock);
                        n++;
                end
                #2;
                if (reset !== 1'b0)
                begin
                        $display("Timeout: reset was never released");
                        other_errors++;
                end

                reset_values();
                lock_and_slip();
                descramble_data();
                classify_control();
                high_ber();
                loss_of_lock();
                header_error();

                $display("Errors: %0d wrong values, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

// ==== verilog/ber_monitor.sv ====
module ber_monitor
        import pcs_monitor_pkg::*;
(
        input  logic     i_clock,
        input  logic     i_reset,
        pcs_block_if.snk in,
        pcs_block_if.src out,
        output logic     o_hi_ber
);

        logic [2:0]               state;
        logic [2:0]               next_state;
        logic [BER_WIN_WIDTH-1:0] win_cnt;
        logic [BER_CNT_WIDTH-1:0] err_cnt;
        logic [BER_CNT_WIDTH-1:0] err_total;
        logic                     win_done;
        logic                     clear_cnt;

        // Error count including the block on the input this cycle. It stops
        // at the threshold, which is all the state machine needs to know.
        always_comb
        begin
                err_total = err_cnt;
                if (in.valid && !in.sh_ok && err_cnt != BER_CNT_WIDTH'(HI_BER_THRESHOLD))
                        err_total = err_cnt + 1'b1;
        end

        assign win_done = in.valid && (win_cnt == BER_WIN_WIDTH'(BER_WINDOW_BLOCKS - 1));

        // ==================================================
        // BER state machine
        // ==================================================

        always_comb
        begin
                next_state = state;
                clear_cnt  = 1'b0;
                case (state)
                        BER_INIT:
                        begin
                                next_state = BER_TEST;
                                clear_cnt  = 1'b1;
                        end
                        BER_TEST:
                        begin
                                if (err_total >= BER_CNT_WIDTH'(HI_BER_THRESHOLD))
                                        next_state = BER_HI;
                        end
                        BER_HI:
                        begin
                                // Leave only after a window that stayed below threshold.
                                if (win_done && err_total < BER_CNT_WIDTH'(HI_BER_THRESHOLD))
                                        next_state = BER_TEST;
                        end
                        default:
                        begin
                                next_state = BER_INIT;
                        end
                endcase
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset || !in.locked)
                begin
                        state    <= BER_INIT;
                        o_hi_ber <= 1'b0;
                end
                else
                begin
                        state    <= next_state;
                        o_hi_ber <= (next_state == BER_HI);
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset || !in.locked || clear_cnt || win_done)
                begin
                        win_cnt <= '0;
                        err_cnt <= '0;
                end
                else if (in.valid)
                begin
                        win_cnt <= win_cnt + 1'b1;
                        err_cnt <= err_total;
                end
        end

        // ==================================================
        // Stream register
        // ==================================================

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        out.valid  <= 1'b0;
                        out.locked <= 1'b0;
                end
                else
                begin
                        out.valid  <= in.valid;
                        out.locked <= in.locked;
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (in.valid)
                begin
                        out.sh      <= in.sh;
                        out.payload <= in.payload;
                        out.sh_ok   <= in.sh_ok;
                end
        end

endmodule

// ==== verilog/block_lock.sv ====
module block_lock
        import pcs_block_pkg::*;
        import pcs_monitor_pkg::*;
(
        input  logic                   i_clock,
        input  logic                   i_reset,
        input  logic                   i_valid,
        input  logic [BLOCK_WIDTH-1:0] i_block,
        output logic                   o_slip,
        pcs_block_if.src               out
);

        logic [SH_WIDTH-1:0]         sh;
        logic                        sh_ok;
        logic                        locked;
        logic [LOCK_CNT_WIDTH-1:0]   good_cnt;
        logic [UNLOCK_WIN_WIDTH-1:0] win_cnt;
        logic [UNLOCK_BAD_WIDTH-1:0] bad_cnt;

        assign sh    = i_block[BLOCK_WIDTH-1 -: SH_WIDTH];
        assign sh_ok = (sh == SH_DATA) || (sh == SH_CTRL);

        // ==================================================
        // Lock state machine
        // ==================================================

        // Unlocked, it waits for a run of good headers and asks the gearbox
        // to slip on every bad one. Locked, it judges each window of blocks.
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        locked   <= 1'b0;
                        good_cnt <= '0;
                        win_cnt  <= '0;
                        bad_cnt  <= '0;
                        o_slip   <= 1'b0;
                end
                else
                begin
                        o_slip <= 1'b0;
                        if (i_valid && !locked)
                        begin
                                if (!sh_ok)
                                begin
                                        good_cnt <= '0;
                                        o_slip   <= 1'b1;
                                end
                                else if (good_cnt == LOCK_CNT_WIDTH'(LOCK_GOOD_COUNT - 1))
                                begin
                                        locked   <= 1'b1;
                                        good_cnt <= '0;
                                end
                                else
                                begin
                                        good_cnt <= good_cnt + 1'b1;
                                end
                        end
                        else if (i_valid)
                        begin
                                // Too many bad headers in this window.
                                if (!sh_ok &&
                                    bad_cnt == UNLOCK_BAD_WIDTH'(UNLOCK_BAD_LIMIT - 1))
                                begin
                                        locked  <= 1'b0;
                                        win_cnt <= '0;
                                        bad_cnt <= '0;
                                end
                                else if (win_cnt == UNLOCK_WIN_WIDTH'(UNLOCK_WINDOW - 1))
                                begin
                                        win_cnt <= '0;
                                        bad_cnt <= '0;
                                end
                                else
                                begin
                                        win_cnt <= win_cnt + 1'b1;
                                        bad_cnt <= bad_cnt + UNLOCK_BAD_WIDTH'(!sh_ok);
                                end
                        end
                end
        end

        // ==================================================
        // Block register
        // ==================================================

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        out.valid <= 1'b0;
                else
                        out.valid <= i_valid;
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                begin
                        out.sh      <= sh;
                        out.payload <= i_block[PAYLOAD_WIDTH-1:0];
                        out.sh_ok   <= sh_ok;
                end
        end

        // The lock flag leaves straight from its own register.
        assign out.locked = locked;

endmodule

// ==== verilog/descrambler.sv ====
module descrambler
        import pcs_block_pkg::*;
(
        input  logic                     i_clock,
        input  logic                     i_reset,
        pcs_block_if.snk                 in,
        output logic                     o_valid,
        output logic                     o_is_ctrl,
        output logic                     o_sh_error,
        output logic [7:0]               o_block_type,
        output logic [PAYLOAD_WIDTH-1:0] o_data
);

        logic [SCR_LEN-1:0]               scr_state;
        logic [PAYLOAD_WIDTH+SCR_LEN-1:0] ext;
        logic [PAYLOAD_WIDTH-1:0]         plain;
        block_payload_t                   pl;
        logic                             is_ctrl;

        // ==================================================
        // Parallel descrambler
        // ==================================================

        // The received bits are laid out oldest first, with the 58 bits kept
        // from earlier blocks below the new payload. Bit i of the payload
        // then sits at ext[i + 58], and its taps at i + 19 and i.
        always_comb
        begin
                ext = {in.payload, scr_state};
                for (int i = 0; i < PAYLOAD_WIDTH; i++)
                        plain[i] = ext[i + SCR_LEN] ^ ext[i + SCR_LEN - SCR_TAP] ^ ext[i];
        end

        // The state holds the last 58 received scrambled bits.
        always_ff @(posedge i_clock)
        begin
                if (in.valid)
                        scr_state <= ext[PAYLOAD_WIDTH+SCR_LEN-1 -: SCR_LEN];
        end

        assign pl      = plain;
        assign is_ctrl = (in.sh == SH_CTRL);

        // ==================================================
        // Output register
        // ==================================================

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        o_valid <= 1'b0;
                else
                        o_valid <= in.valid;
        end

        always_ff @(posedge i_clock)
        begin
                if (in.valid)
                begin
                        o_is_ctrl    <= is_ctrl;
                        o_sh_error   <= !in.sh_ok;
                        o_data       <= pl.data;
                        o_block_type <= is_ctrl ? pl.ctrl.block_type : 8'h00;
                end
        end

endmodule

// ==== verilog/pcs_block_if.sv ====
interface pcs_block_if
        import pcs_block_pkg::*;
();

        // Each block comes with one strobe and a header that is already checked.
        logic                     valid;
        logic [SH_WIDTH-1:0]      sh;
        logic [PAYLOAD_WIDTH-1:0] payload;
        logic                     sh_ok;
        logic                     locked;

        modport src
        (
                output valid,
                output sh,
                output payload,
                output sh_ok,
                output locked
        );

        modport snk
        (
                input  valid,
                input  sh,
                input  payload,
                input  sh_ok,
                input  locked
        );

endinterface

// ==== verilog/pcs_block_pkg.sv ====
package pcs_block_pkg;

        // ==================================================
        // 64b/66b block format
        // ==================================================

        localparam int SH_WIDTH      = 2;
        localparam int PAYLOAD_WIDTH = 64;
        localparam int BLOCK_WIDTH   = SH_WIDTH + PAYLOAD_WIDTH;

        // Only these two header values are legal. 00 and 11 are errors.
        localparam logic [SH_WIDTH-1:0] SH_DATA = 2'b01;
        localparam logic [SH_WIDTH-1:0] SH_CTRL = 2'b10;

        // Self-synchronizing scrambler polynomial x^58 + x^39 + 1.
        localparam int SCR_LEN = 58;
        localparam int SCR_TAP = 39;

        // ==================================================
        // Payload views
        // ==================================================

        // The same 64-bit word is read as eight data bytes or, for a
        // control block, as a type byte in the low octet plus the body.
        typedef union packed {
                logic [7:0][7:0] data;
                struct packed {
                        logic [55:0] body;
                        logic [7:0]  block_type;
                } ctrl;
        } block_payload_t;

endpackage

// ==== verilog/pcs_monitor_pkg.sv ====
package pcs_monitor_pkg;

        // ==================================================
        // Block lock policy
        // ==================================================

        localparam int LOCK_GOOD_COUNT  = 64;
        localparam int UNLOCK_WINDOW    = 64;
        localparam int UNLOCK_BAD_LIMIT = 16;

        // ==================================================
        // BER monitor policy
        // ==================================================

        // The window is counted in blocks, not in the 125 us timer.
        localparam int BER_WINDOW_BLOCKS = 128;
        localparam int HI_BER_THRESHOLD  = 8;

        // Each counter is wide enough to hold its full count.
        localparam int LOCK_CNT_WIDTH   = $clog2(LOCK_GOOD_COUNT + 1);
        localparam int UNLOCK_WIN_WIDTH = $clog2(UNLOCK_WINDOW + 1);
        localparam int UNLOCK_BAD_WIDTH = $clog2(UNLOCK_BAD_LIMIT + 1);
        localparam int BER_WIN_WIDTH    = $clog2(BER_WINDOW_BLOCKS + 1);
        localparam int BER_CNT_WIDTH    = $clog2(HI_BER_THRESHOLD + 1);

        // One-hot encoding of the BER monitor states.
        localparam logic [2:0] BER_INIT = 3'b001;
        localparam logic [2:0] BER_TEST = 3'b010;
        localparam logic [2:0] BER_HI   = 3'b100;

endpackage

// ==== verilog/pcs_rx.sv ====
module pcs_rx
        import pcs_block_pkg::*;
(
        input  logic                     i_clock,
        input  logic                     i_reset,
        input  logic                     i_valid,
        input  logic [BLOCK_WIDTH-1:0]   i_block,
        output logic                     o_slip,
        output logic                     o_block_lock,
        output logic                     o_hi_ber,
        output logic                     o_valid,
        output logic                     o_is_ctrl,
        output logic [7:0]               o_block_type,
        output logic [PAYLOAD_WIDTH-1:0] o_data,
        output logic                     o_sh_error
);

        // Stage 1 to stage 2, and stage 2 to stage 3.
        pcs_block_if lock_to_ber ();
        pcs_block_if ber_to_desc ();

        block_lock block_lock_i
        (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .i_valid (i_valid),
                .i_block (i_block),
                .o_slip  (o_slip),
                .out     (lock_to_ber.src)
        );

        // Lock status is taken straight from the stage 1 register.
        assign o_block_lock = lock_to_ber.locked;

        ber_monitor ber_monitor_i
        (
                .i_clock  (i_clock),
                .i_reset  (i_reset),
                .in       (lock_to_ber.snk),
                .out      (ber_to_desc.src),
                .o_hi_ber (o_hi_ber)
        );

        descrambler descrambler_i
        (
                .i_clock      (i_clock),
                .i_reset      (i_reset),
                .in           (ber_to_desc.snk),
                .o_valid      (o_valid),
                .o_is_ctrl    (o_is_ctrl),
                .o_sh_error   (o_sh_error),
                .o_block_type (o_block_type),
                .o_data       (o_data)
        );

endmodule
